// File: design/branch_resolve_top.sv
// resolves one instruction per cycle with 2-cycle latency; no redirect or flush is issued from here
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,

    // issue port
    input  logic                     issue_valid_i,
    output logic                     issue_ready_o,
    input  riscv_isa_pkg::addr_t     issue_pc_i,
    input  riscv_isa_pkg::instr_t    issue_instr_i,
    input  riscv_isa_pkg::bus64_t    issue_rs1_i,
    input  riscv_isa_pkg::bus64_t    issue_rs2_i,
    input  logic                     issue_pred_taken_i,
    input  riscv_isa_pkg::addr_t     issue_pred_target_i,

    // result port
    output logic                     res_valid_o,
    input  logic                     res_ready_i,
    output logic                     res_taken_o,
    output riscv_isa_pkg::addr_t     res_target_o,
    output riscv_isa_pkg::addr_t     res_next_pc_o,
    output logic                     res_mispredict_o,
    output logic                     res_link_we_o,
    output riscv_isa_pkg::reg_idx_t  res_link_rd_o,
    output riscv_isa_pkg::bus64_t    res_link_data_o
);

    import riscv_isa_pkg::*;
    import ctrl_xfer_pkg::*;

    issue_pkt_t     issue_d;
    issue_pkt_t     issue_q;
    logic           issue_vld;     // issue register occupied
    logic           result_rdy;    // result stage can accept

    ctrl_xfer_op_t  ctrl_xfer_op;
    branch_op_t     branch_op;
    bus64_t         imm;
    reg_idx_t       rd;

    logic           taken;
    addr_t          target;
    addr_t          next_pc;
    bus64_t         link_data;
    logic           mispredict;
    logic           link_we;

    resolve_pkt_t   resolve_d;
    resolve_pkt_t   resolve_q;

    // bundle the loose issue fields
    assign issue_d.pc          = issue_pc_i;
    assign issue_d.instr       = issue_instr_i;
    assign issue_d.rs1         = issue_rs1_i;
    assign issue_d.rs2         = issue_rs2_i;
    assign issue_d.pred_taken  = issue_pred_taken_i;
    assign issue_d.pred_target = issue_pred_target_i;

    pipe_stage #(.payload_t(issue_pkt_t)) issue_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (issue_valid_i),
        .ready_o  (issue_ready_o),
        .data_i   (issue_d),
        .valid_o  (issue_vld),
        .ready_i  (result_rdy),  // backpressure chains through
        .data_o   (issue_q)
    );

    ctrl_xfer_decoder u_decoder (
        .instr_i        (issue_q.instr),
        .ctrl_xfer_op_o (ctrl_xfer_op),
        .branch_op_o    (branch_op),
        .imm_o          (imm),
        .rd_o           (rd)
    );

    branch_unit u_branch_unit (
        .ctrl_xfer_op_i (ctrl_xfer_op),
        .branch_op_i    (branch_op),
        .pc_i           (issue_q.pc),
        .data_rs1_i     (issue_q.rs1),
        .data_rs2_i     (issue_q.rs2),
        .imm_i          (imm),
        .taken_o        (taken),
        .target_o       (target),
        .result_o       (next_pc),
        .reg_data_o     (link_data)
    );

    // wrong direction, or right direction but wrong place
    assign mispredict = (issue_q.pred_taken != taken) ||
                        (taken && issue_q.pred_taken && (issue_q.pred_target != target));

    // x0 destination writes nothing
    assign link_we = ((ctrl_xfer_op == CT_JAL) || (ctrl_xfer_op == CT_JALR)) && (rd != '0);

    assign resolve_d.taken      = taken;
    assign resolve_d.target     = target;
    assign resolve_d.next_pc    = next_pc;
    assign resolve_d.mispredict = mispredict;
    assign resolve_d.link_we    = link_we;
    assign resolve_d.link_rd    = rd;
    assign resolve_d.link_data  = link_data;

    pipe_stage #(.payload_t(resolve_pkt_t)) result_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (issue_vld),
        .ready_o  (result_rdy),
        .data_i   (resolve_d),
        .valid_o  (res_valid_o),
        .ready_i  (res_ready_i),
        .data_o   (resolve_q)
    );

    // unpack onto the result port
    assign res_taken_o      = resolve_q.taken;
    assign res_target_o     = resolve_q.target;
    assign res_next_pc_o    = resolve_q.next_pc;
    assign res_mispredict_o = resolve_q.mispredict;
    assign res_link_we_o    = resolve_q.link_we;
    assign res_link_rd_o    = resolve_q.link_rd;
    assign res_link_data_o  = resolve_q.link_data;

endmodule

`default_nettype wire

// File: design/branch_unit.sv
// purely combinational; no misaligned-target trap, jalr target is rs1+imm with bit 0 cleared
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  ctrl_xfer_pkg::ctrl_xfer_op_t  ctrl_xfer_op_i,
    input  ctrl_xfer_pkg::branch_op_t     branch_op_i,

    input  riscv_isa_pkg::addr_t          pc_i,
    input  riscv_isa_pkg::bus64_t         data_rs1_i,
    input  riscv_isa_pkg::bus64_t         data_rs2_i,
    input  riscv_isa_pkg::bus64_t         imm_i,

    output logic                          taken_o,
    output riscv_isa_pkg::addr_t          target_o,
    output riscv_isa_pkg::addr_t          result_o,
    output riscv_isa_pkg::bus64_t         reg_data_o
);

    import riscv_isa_pkg::*;
    import ctrl_xfer_pkg::*;

    logic   equal;
    logic   less;      // signed compare
    logic   less_u;    // unsigned compare
    logic   cond_met;  // branch condition result
    addr_t  pc_rel;    // pc + imm, shared by jal and branch
    addr_t  jalr_sum;
    addr_t  pc_next;   // sequential pc

    assign equal  = (data_rs1_i == data_rs2_i);
    assign less   = ($signed(data_rs1_i) < $signed(data_rs2_i));
    assign less_u = (data_rs1_i < data_rs2_i);

    assign pc_rel   = pc_i + imm_i;
    assign jalr_sum = data_rs1_i + imm_i;
    assign pc_next  = pc_i + INSTR_BYTES;

    // condition select, reserved funct3 never taken
    always_comb begin
        case (branch_op_i)
            B_EQ:    cond_met = equal;
            B_NE:    cond_met = ~equal;
            B_LT:    cond_met = less;
            B_GE:    cond_met = ~less;
            B_LTU:   cond_met = less_u;
            B_GEU:   cond_met = ~less_u;
            default: cond_met = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl_xfer_op_i)
            CT_JAL: begin
                taken_o  = 1'b1;               // unconditional
                target_o = pc_rel;
            end
            CT_JALR: begin
                taken_o  = 1'b1;
                target_o = {jalr_sum[XLEN-1:1], 1'b0}; // isa clears lsb
            end
            CT_BRANCH: begin
                taken_o  = cond_met;
                target_o = pc_rel;             // reported even when not taken
            end
            default: begin
                taken_o  = 1'b0;
                target_o = '0;
            end
        endcase
    end

    assign result_o   = taken_o ? target_o : pc_next; // next pc
    assign reg_data_o = pc_next;                      // link value

endmodule

`default_nettype wire

// File: design/ctrl_xfer_decoder.sv
// decodes by opcode alone; jalr funct3 is not checked and illegal words decode as CT_NONE
`timescale 1ns/1ps
`default_nettype none

module ctrl_xfer_decoder (
    input  riscv_isa_pkg::instr_t         instr_i,

    output ctrl_xfer_pkg::ctrl_xfer_op_t  ctrl_xfer_op_o,
    output ctrl_xfer_pkg::branch_op_t     branch_op_o,
    output riscv_isa_pkg::bus64_t         imm_o,
    output riscv_isa_pkg::reg_idx_t       rd_o
);

    import riscv_isa_pkg::*;
    import ctrl_xfer_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    bus64_t     j_imm;   // jal offset
    bus64_t     i_imm;   // jalr offset
    bus64_t     b_imm;   // conditional branch offset

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign rd_o   = instr_i[11:7]; // passed on regardless of kind

    // j-type, offset is a multiple of 2
    assign j_imm = {{(XLEN-20){instr_i[31]}},
                    instr_i[19:12],
                    instr_i[20],
                    instr_i[30:21],
                    1'b0};

    // i-type, plain 12 bit
    assign i_imm = {{(XLEN-12){instr_i[31]}}, instr_i[31:20]};

    // b-type, scrambled 13 bit with implied lsb
    assign b_imm = {{(XLEN-12){instr_i[31]}},
                    instr_i[7],
                    instr_i[30:25],
                    instr_i[11:8],
                    1'b0};

    // transfer kind and immediate by opcode
    always_comb begin
        case (opcode)
            OPC_JAL: begin
                ctrl_xfer_op_o = CT_JAL;
                imm_o          = j_imm;
            end
            OPC_JALR: begin
                ctrl_xfer_op_o = CT_JALR;
                imm_o          = i_imm;
            end
            OPC_BRANCH: begin
                ctrl_xfer_op_o = CT_BRANCH;
                imm_o          = b_imm;
            end
            default: begin
                ctrl_xfer_op_o = CT_NONE; // alu, load, store, ...
                imm_o          = '0;
            end
        endcase
    end

    // condition only matters for branches
    always_comb begin
        if (opcode == OPC_BRANCH) begin
            case (funct3)
                F3_BEQ:  branch_op_o = B_EQ;
                F3_BNE:  branch_op_o = B_NE;
                F3_BLT:  branch_op_o = B_LT;
                F3_BGE:  branch_op_o = B_GE;
                F3_BLTU: branch_op_o = B_LTU;
                F3_BGEU: branch_op_o = B_GEU;
                default: branch_op_o = B_NONE; // reserved 010/011
            endcase
        end else begin
            branch_op_o = B_NONE;
        end
    end

endmodule

`default_nettype wire

// File: design/ctrl_xfer_pkg.sv
// stage payloads assume the riscv_isa_pkg widths; enum values are internal and not tied to isa bits
`default_nettype none

package ctrl_xfer_pkg;

    // kind of control transfer, CT_NONE for everything else
    typedef enum logic [1:0] {
        CT_NONE   = 2'd0,
        CT_JAL    = 2'd1,
        CT_JALR   = 2'd2,
        CT_BRANCH = 2'd3
    } ctrl_xfer_op_t;

    // branch condition, B_NONE covers reserved funct3
    typedef enum logic [2:0] {
        B_EQ   = 3'd0,
        B_NE   = 3'd1,
        B_LT   = 3'd2,
        B_GE   = 3'd3,
        B_LTU  = 3'd4,
        B_GEU  = 3'd5,
        B_NONE = 3'd6
    } branch_op_t;

    // what the issue register holds
    typedef struct packed {
        riscv_isa_pkg::addr_t  pc;
        riscv_isa_pkg::instr_t instr;
        riscv_isa_pkg::bus64_t rs1;          // operand values, already read
        riscv_isa_pkg::bus64_t rs2;
        logic                  pred_taken;   // front end guess
        riscv_isa_pkg::addr_t  pred_target;  // only meaningful when pred_taken
    } issue_pkt_t;

    // what the result register holds
    typedef struct packed {
        logic                     taken;
        riscv_isa_pkg::addr_t     target;
        riscv_isa_pkg::addr_t     next_pc;    // target or pc+4
        logic                     mispredict;
        logic                     link_we;    // jal/jalr with rd != x0
        riscv_isa_pkg::reg_idx_t  link_rd;
        riscv_isa_pkg::bus64_t    link_data;  // return address
    } resolve_pkt_t;

endpackage

`default_nettype wire

// File: design/pipe_stage.sv
// one entry, full throughput only because ready_o looks through to ready_i combinationally
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic      clk_i,
    input  logic      arst_n_i,

    // upstream side
    input  logic      valid_i,
    output logic      ready_o,
    input  payload_t  data_i,

    // downstream side
    output logic      valid_o,
    input  logic      ready_i,
    output payload_t  data_o
);

    logic      valid_q;
    payload_t  data_q;   // meaningful only while valid_q is set

    // can take a new entry when empty or when the current one leaves now
    assign ready_o = ~valid_q | ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i; // load or drain to empty
        end
    end

    // payload only moves on an actual transfer
    always_ff @(posedge clk_i) begin
        if (ready_o && valid_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

// File: design/riscv_isa_pkg.sv
// rv64i base encodings only; no compressed or extension opcodes, pc step fixed at 4 bytes
`default_nettype none

package riscv_isa_pkg;

    // data path width
    localparam int unsigned XLEN = 64;

    typedef logic [XLEN-1:0] bus64_t;   // register operand
    typedef logic [XLEN-1:0] addr_t;    // pc / target address
    typedef logic [31:0]     instr_t;   // raw instruction word
    typedef logic [4:0]      reg_idx_t; // x0..x31

    // next sequential pc offset, no rvc support
    localparam addr_t INSTR_BYTES = addr_t'(4);

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // branch funct3, instr[14:12]
    // 3'b010 and 3'b011 are reserved in the isa
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and judges the run from its log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module branch_resolve_tb -Mdir obj_dir -f sim.f

status=0
./obj_dir/Vbranch_resolve_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Done: no errors" sim.log; then
    echo "simulation FAILED: run did not complete"
    exit 1
fi
echo "simulation PASSED"

// File: sim.f
design/riscv_isa_pkg.sv
design/ctrl_xfer_pkg.sv
design/ctrl_xfer_decoder.sv
design/branch_unit.sv
design/pipe_stage.sv
design/branch_resolve_top.sv
verif/tb_clock_gen.sv
verif/branch_resolve_tb.sv

// File: verif/branch_resolve_tb.sv
// one LFSR stream feeds instructions, predictions and back-pressure; stops at the first error
`timescale 1ns/1ps
`default_nettype none

module branch_resolve_tb;

    import riscv_isa_pkg::*;
    import ctrl_xfer_pkg::*;

    logic          clk;
    logic          arst_n;
    logic          issue_valid;
    logic          issue_ready;
    addr_t         issue_pc;
    instr_t        issue_instr;
    bus64_t        issue_rs1;
    bus64_t        issue_rs2;
    logic          issue_pred_taken;
    addr_t         issue_pred_target;
    logic          res_valid;
    logic          res_ready;
    logic          res_taken;
    addr_t         res_target;
    addr_t         res_next_pc;
    logic          res_mispredict;
    logic          res_link_we;
    reg_idx_t      res_link_rd;
    bus64_t        res_link_data;

    logic [31:0]   lfsr_state;
    int            cyc;        // rising edges since the first phase began
    logic          throttle;   // random res_ready in this phase
    resolve_pkt_t  cur_exp;    // model output for the instruction on the issue port
    string         cur_name;
    resolve_pkt_t  exp_q[$];   // scoreboard in issue order
    string         name_q[$];
    int            stamp_q[$]; // cycle of the issue handshake

    tb_clock_gen #(.PERIOD(4.0)) u_clk (.clk_o(clk));

    branch_resolve_top uut (
        .clk_i               (clk),
        .arst_n_i            (arst_n),
        .issue_valid_i       (issue_valid),
        .issue_ready_o       (issue_ready),
        .issue_pc_i          (issue_pc),
        .issue_instr_i       (issue_instr),
        .issue_rs1_i         (issue_rs1),
        .issue_rs2_i         (issue_rs2),
        .issue_pred_taken_i  (issue_pred_taken),
        .issue_pred_target_i (issue_pred_target),
        .res_valid_o         (res_valid),
        .res_ready_i         (res_ready),
        .res_taken_o         (res_taken),
        .res_target_o        (res_target),
        .res_next_pc_o       (res_next_pc),
        .res_mispredict_o    (res_mispredict),
        .res_link_we_o       (res_link_we),
        .res_link_rd_o       (res_link_rd),
        .res_link_data_o     (res_link_data)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit with the newest bit at the lsb
    function automatic logic [63:0] rand_bits(input int unsigned n);
        logic [63:0] r;
        r = '0;
        for (int unsigned i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[62:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic rand_bit();
        logic [63:0] r;
        r = rand_bits(1);
        return r[0];
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input addr_t exp_v, input addr_t act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s: expected %h actual %h", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input bus64_t exp_v, input bus64_t act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s: expected %h actual %h", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t exp_v, input reg_idx_t act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s: expected %0d actual %0d", name, exp_v, act_v);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s: expected %b actual %b", name, exp_v, act_v);
            abort_run();
        end
    endtask

    // random instruction plus its expected result from the isa rules
    task automatic make_instr(input int idx);
        logic [63:0] r;
        logic [1:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [20:0] off;
        logic [6:0]  opc;
        addr_t       pc;
        bus64_t      a;
        bus64_t      b;
        bus64_t      sext;
        addr_t       tgt;
        addr_t       ptgt;
        logic        tk;
        logic        pt;
        instr_t      ins;
        string       base;
        r = rand_bits(64);
        pc = {r[63:2], 2'b00};               // word aligned
        a = rand_bits(64);
        r = rand_bits(2);
        if (r[1:0] == 2'd0) begin
            b = a;                           // forced equal
        end else if (r[1:0] == 2'd1) begin
            b = a ^ {1'b1, 63'b0};           // differ in sign bit only
        end else begin
            b = rand_bits(64);
        end
        r = rand_bits(31);
        rd = r[4:0];
        off = r[25:5];
        f3 = r[28:26];
        kind = r[30:29];
        case (kind)
            2'd0: begin
                sext = {{43{off[20]}}, off[20:1], 1'b0};
                ins = {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
                tk = 1'b1;
                tgt = pc + sext;
                base = "jal";
            end
            2'd1: begin
                sext = {{52{off[11]}}, off[11:0]};
                ins = {off[11:0], off[16:12], 3'b000, rd, OPC_JALR};
                tk = 1'b1;
                tgt = (a + sext) & ~64'h1;   // lsb dropped
                base = "jalr";
            end
            2'd2: begin
                sext = {{51{off[12]}}, off[12:1], 1'b0};
                ins = {off[12], off[10:5], off[17:13], off[20:16], f3, off[4:1], off[11],
                       OPC_BRANCH};
                tgt = pc + sext;             // kept even when not taken
                case (f3)
                    3'b000:  tk = (a == b);
                    3'b001:  tk = (a != b);
                    3'b100:  tk = ($signed(a) < $signed(b));
                    3'b101:  tk = ($signed(a) >= $signed(b));
                    3'b110:  tk = (a < b);
                    3'b111:  tk = (a >= b);
                    default: tk = 1'b0;      // reserved funct3
                endcase
                base = $sformatf("branch_f3_%b", f3);
            end
            default: begin
                r = rand_bits(27);
                case (r[26:25])
                    2'd0:    opc = 7'b0110011; // op
                    2'd1:    opc = 7'b0010011; // op-imm
                    2'd2:    opc = 7'b0000011; // load
                    default: opc = 7'b0100011; // store
                endcase
                ins = {r[24:0], opc};
                tk = 1'b0;
                tgt = '0;
                base = "other";
            end
        endcase
        r = rand_bits(2);
        pt = r[0];
        ptgt = r[1] ? tgt : rand_bits(64);   // half the guesses hit the target
        cur_exp.taken = tk;
        cur_exp.target = tgt;
        cur_exp.next_pc = tk ? tgt : pc + 64'd4;
        if (pt != tk) begin
            cur_exp.mispredict = 1'b1;       // wrong direction
        end else begin
            cur_exp.mispredict = tk && (ptgt != tgt);
        end
        cur_exp.link_we = (kind == 2'd0 || kind == 2'd1) && (rd != 5'd0);
        cur_exp.link_rd = rd;
        cur_exp.link_data = pc + 64'd4;
        cur_name = $sformatf("%s_%0d", base, idx);
        issue_pc <= pc;
        issue_instr <= ins;
        issue_rs1 <= a;
        issue_rs2 <= b;
        issue_pred_taken <= pt;
        issue_pred_target <= ptgt;
    endtask

    task automatic check_result();
        resolve_pkt_t e;
        string        n;
        int           stamp;
        if (exp_q.size() == 0) begin
            $display("result handshake seen with no instruction outstanding");
            abort_run();
        end else begin
            e = exp_q.pop_front();
            n = name_q.pop_front();
            stamp = stamp_q.pop_front();
            check_bit({n, " taken"}, e.taken, res_taken);
            check_addr({n, " target"}, e.target, res_target);
            check_addr({n, " next_pc"}, e.next_pc, res_next_pc);
            check_bit({n, " mispredict"}, e.mispredict, res_mispredict);
            check_bit({n, " link_we"}, e.link_we, res_link_we);
            if (e.link_we) begin
                check_reg({n, " link_rd"}, e.link_rd, res_link_rd);
                check_data({n, " link_data"}, e.link_data, res_link_data);
            end
            if (!throttle && (cyc - stamp != 2)) begin
                $display("MISMATCH %s latency: expected 2 actual %0d", n, cyc - stamp);
                abort_run();
            end
        end
    endtask

    // sample pre-edge values first and drive with nba on the same edge
    task automatic run_phase(input int count, input logic bp);
        int   sent;
        int   guard;
        logic pending;
        sent = 0;
        guard = 0;
        pending = 1'b0;
        throttle = bp;
        while (sent < count || pending || exp_q.size() != 0) begin
            @(posedge clk);
            cyc++;
            guard++;
            if (guard > count * 20 + 100) begin
                $display("timeout: %0d of %0d issued, %0d results outstanding",
                         sent, count, exp_q.size());
                abort_run();
            end
            if (issue_valid && issue_ready) begin
                exp_q.push_back(cur_exp);
                name_q.push_back(cur_name);
                stamp_q.push_back(cyc);
                sent++;
                pending = 1'b0;
            end
            if (res_valid && res_ready) begin
                check_result();
            end
            if (!pending && sent < count && (!bp || rand_bit())) begin
                make_instr(sent);
                issue_valid <= 1'b1;
                pending = 1'b1;
            end else if (!pending) begin
                issue_valid <= 1'b0;          // idle gap
            end
            res_ready <= bp ? rand_bit() : 1'b1;
        end
        issue_valid <= 1'b0;
    endtask

    // nothing may leave the result port once every issued instruction came back
    task automatic check_drained(input int cycles);
        res_ready <= 1'b1;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (res_valid) begin
                $display("result presented after the last issued instruction came back");
                abort_run();
            end
        end
    endtask

    initial begin
        lfsr_state = 32'h3c50;
        cyc = 0;
        throttle = 1'b0;
        arst_n = 1'b0;
        issue_valid = 1'b0;
        issue_pc = '0;
        issue_instr = '0;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_pred_taken = 1'b0;
        issue_pred_target = '0;
        res_ready = 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        arst_n <= 1'b1;
        @(posedge clk);
        check_bit("after_reset res_valid", 1'b0, res_valid);     // both stages empty
        check_bit("after_reset issue_ready", 1'b1, issue_ready);
        run_phase(200, 1'b0);  // full rate with fixed latency
        run_phase(800, 1'b1);  // random back-pressure and gaps
        check_drained(8);      // no duplicate after the last result
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// free-running clock from time zero, starts low; no enable and no jitter
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD = 4.0  // ns
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2.0) clk_o = ~clk_o; // half period per toggle
        end
    end

endmodule

`default_nettype wire
